// ==== source/i2c_bridge_pkg.sv ====
`default_nettype none

package i2c_bridge_pkg;

  // wishbone widths
  localparam int wb_addr_w = 6;
  localparam int wb_data_w = 32;

  // command register word address
  localparam logic [wb_addr_w-1:0] cmd_reg_addr = 6'h3d;

  // clk cycles per quarter of an scl bit
  localparam int quarter_cycles = 8;

  typedef enum logic [7:0] {
    OP_NOP    = 8'h00,
    OP_WRITE2 = 8'h06
  } cmd_op_e;

  typedef enum logic {
    CMD_IDLE,
    CMD_WAIT
  } cmd_state_e;

  typedef enum logic [1:0] {
    MST_IDLE,
    MST_START,
    MST_BYTE,
    MST_STOP
  } mst_state_e;

endpackage

`default_nettype wire

// ==== source/wb_i2c_cmd.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_i2c_cmd import i2c_bridge_pkg::*; (
  input  wire                  clk,
  input  wire                  rst,
  input  wire [wb_addr_w-1:0]  wbs_adr_i,
  input  wire [wb_data_w-1:0]  wbs_dat_i,
  input  wire                  wbs_we_i,
  input  wire                  wbs_stb_i,
  input  wire                  wbs_cyc_i,
  output logic                 wbs_ack_o,
  input  wire                  busy_i,
  output logic                 xfer_go_o,
  output logic [6:0]           xfer_addr_o,
  output logic [7:0]           xfer_data0_o,
  output logic [7:0]           xfer_data1_o
);

  cmd_state_e state;
  cmd_op_e    op;
  logic       accept;

  // opcode sits in the top byte
  assign op = cmd_op_e'(wbs_dat_i[wb_data_w-1 -: 8]);

  assign accept = wbs_cyc_i && wbs_stb_i && wbs_we_i &&
                  (wbs_adr_i == cmd_reg_addr) &&
                  (op == OP_WRITE2) &&
                  (state == CMD_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= CMD_IDLE;
      wbs_ack_o <= 1'b0;
      xfer_go_o <= 1'b0;
    end else begin
      wbs_ack_o <= accept;
      xfer_go_o <= accept;
      case (state)
        CMD_IDLE: begin
          if (accept) begin
            state <= CMD_WAIT;
          end
        end
        CMD_WAIT: begin
          // busy rises one cycle after go, so skip the go cycle
          if (!busy_i && !xfer_go_o) begin
            state <= CMD_IDLE;
          end
        end
        default: state <= CMD_IDLE;
      endcase
    end
  end

  // transaction fields, held until the next accepted write
  always_ff @(posedge clk) begin
    if (accept) begin
      xfer_addr_o  <= wbs_dat_i[22:16];
      xfer_data0_o <= wbs_dat_i[15:8];
      xfer_data1_o <= wbs_dat_i[7:0];
    end
  end

  // single-cycle ack even when the host keeps strobing
  assert property (@(posedge clk) disable iff (rst)
    wbs_ack_o |=> !wbs_ack_o);

endmodule

`default_nettype wire

// ==== source/i2c_bit_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_timer import i2c_bridge_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  input  wire        run_i,
  input  wire        scl_i,
  output logic       phase_tick_o,
  output logic [1:0] phase_o
);

  logic [$clog2(quarter_cycles)-1:0] cnt;

  always_ff @(posedge clk) begin
    if (rst || !run_i) begin
      cnt          <= '0;
      phase_o      <= 2'd0;
      phase_tick_o <= 1'b0;
    end else if ((phase_o == 2'd2) && !scl_i) begin
      // target still holds scl low
      cnt          <= '0;
      phase_tick_o <= 1'b0;
    end else if (int'(cnt) == quarter_cycles - 1) begin
      cnt          <= '0;
      phase_o      <= phase_o + 2'd1;
      phase_tick_o <= 1'b1;
    end else begin
      cnt          <= cnt + 1'b1;
      phase_tick_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== source/i2c_byte_shift.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_byte_shift (
  input  wire        clk,
  input  wire        rst,
  input  wire        load_i,
  input  wire [7:0]  byte_i,
  input  wire        phase_tick_i,
  input  wire [1:0]  phase_i,
  input  wire        sda_i,
  output logic       sda_release_o,
  output logic       byte_done_o,
  output logic       nack_o
);

  logic [7:0] shreg;
  logic [3:0] bit_cnt;
  logic       armed;
  logic       active;
  logic       bit_start;

  assign bit_start = active && phase_tick_i && (phase_i == 2'd0);

  // ninth bit ends with scl high, nack already sampled
  assign byte_done_o = active && phase_tick_i && (phase_i == 2'd3) && (bit_cnt == 4'd8);

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt       <= 4'd0;
      armed         <= 1'b0;
      active        <= 1'b0;
      sda_release_o <= 1'b1;
      nack_o        <= 1'b0;
    end else if (load_i) begin
      bit_cnt       <= 4'd0;
      armed         <= 1'b1;
      active        <= 1'b1;
      // keep sda low until scl has fallen
      sda_release_o <= 1'b0;
    end else if (active && phase_tick_i) begin
      case (phase_i)
        2'd0: begin
          if (armed) begin
            armed         <= 1'b0;
            sda_release_o <= shreg[7];
          end else begin
            bit_cnt       <= bit_cnt + 4'd1;
            sda_release_o <= shreg[6];
          end
        end
        2'd2: begin
          if (bit_cnt == 4'd8) begin
            nack_o <= sda_i;
          end
        end
        2'd3: begin
          if (bit_cnt == 4'd8) begin
            active <= 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

  // ones shift in, so the ack bit is released
  always_ff @(posedge clk) begin
    if (load_i) begin
      shreg <= byte_i;
    end else if (bit_start && !armed) begin
      shreg <= {shreg[6:0], 1'b1};
    end
  end

endmodule

`default_nettype wire

// ==== source/i2c_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_master import i2c_bridge_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  input  wire        xfer_go_i,
  input  wire [6:0]  xfer_addr_i,
  input  wire [7:0]  xfer_data0_i,
  input  wire [7:0]  xfer_data1_i,
  input  wire        scl_i,
  input  wire        sda_i,
  output logic       busy_o,
  output logic       missed_ack_o,
  output logic       scl_t_o,
  output logic       sda_t_o
);

  mst_state_e state;
  logic [1:0] byte_idx;
  logic [1:0] next_idx;
  logic       nacked;
  logic       stop_low;
  logic       run;
  logic       phase_tick;
  logic [1:0] phase;
  logic       start_end;
  logic       stop_end;
  logic       load;
  logic [7:0] load_byte;
  logic       shift_release;
  logic       byte_done;
  logic       nack;

  assign run       = (state != MST_IDLE);
  assign start_end = (state == MST_START) && phase_tick && (phase == 2'd3);
  assign stop_end  = (state == MST_STOP) && phase_tick && (phase == 2'd3) && stop_low;
  assign next_idx  = (state == MST_START) ? 2'd0 : byte_idx + 2'd1;
  assign load      = start_end ||
                     ((state == MST_BYTE) && byte_done && !nack && (byte_idx != 2'd2));

  // address with write bit, then the two data bytes
  always_comb begin
    case (next_idx)
      2'd0:    load_byte = {xfer_addr_i, 1'b0};
      2'd1:    load_byte = xfer_data0_i;
      default: load_byte = xfer_data1_i;
    endcase
  end

  always_comb begin
    case (state)
      MST_START: begin
        // sda falls halfway through a high scl bit
        scl_t_o = 1'b1;
        sda_t_o = !phase[1];
      end
      MST_BYTE: begin
        scl_t_o = phase[1];
        sda_t_o = shift_release;
      end
      MST_STOP: begin
        scl_t_o = phase[1];
        sda_t_o = stop_low ? (phase == 2'd3) : 1'b1;
      end
      default: begin
        scl_t_o = 1'b1;
        sda_t_o = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= MST_IDLE;
      byte_idx     <= 2'd0;
      nacked       <= 1'b0;
      stop_low     <= 1'b0;
      busy_o       <= 1'b0;
      missed_ack_o <= 1'b0;
    end else begin
      missed_ack_o <= 1'b0;
      case (state)
        MST_IDLE: begin
          if (xfer_go_i) begin
            state    <= MST_START;
            busy_o   <= 1'b1;
            nacked   <= 1'b0;
            stop_low <= 1'b0;
          end
        end
        MST_START: begin
          if (start_end) begin
            state    <= MST_BYTE;
            byte_idx <= next_idx;
          end
        end
        MST_BYTE: begin
          if (byte_done) begin
            if (nack) begin
              state  <= MST_STOP;
              nacked <= 1'b1;
            end else if (byte_idx == 2'd2) begin
              state <= MST_STOP;
            end else begin
              byte_idx <= next_idx;
            end
          end
        end
        MST_STOP: begin
          if (phase_tick && (phase == 2'd0)) begin
            stop_low <= 1'b1;
          end
          if (stop_end) begin
            state        <= MST_IDLE;
            busy_o       <= 1'b0;
            missed_ack_o <= nacked;
          end
        end
        default: state <= MST_IDLE;
      endcase
    end
  end

  i2c_bit_timer u_timer (
    .clk          (clk),
    .rst          (rst),
    .run_i        (run),
    .scl_i        (scl_i),
    .phase_tick_o (phase_tick),
    .phase_o      (phase)
  );

  i2c_byte_shift u_shift (
    .clk           (clk),
    .rst           (rst),
    .load_i        (load),
    .byte_i        (load_byte),
    .phase_tick_i  (phase_tick),
    .phase_i       (phase),
    .sda_i         (sda_i),
    .sda_release_o (shift_release),
    .byte_done_o   (byte_done),
    .nack_o        (nack)
  );

  // within a byte the line only moves while scl is low
  assert property (@(posedge clk) disable iff (rst)
    (state == MST_BYTE) && scl_i && $past(scl_i) |-> $stable(sda_i));

endmodule

`default_nettype wire

// ==== source/i2c_bus_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_bus_bridge import i2c_bridge_pkg::*; (
  input  wire                  clk,
  input  wire                  rst,
  input  wire [wb_addr_w-1:0]  wbs_adr_i,
  input  wire [wb_data_w-1:0]  wbs_dat_i,
  input  wire                  wbs_we_i,
  input  wire                  wbs_stb_i,
  input  wire                  wbs_cyc_i,
  output logic                 wbs_ack_o,
  input  wire                  scl_i,
  input  wire                  sda_i,
  output logic                 scl_t_o,
  output logic                 sda_t_o,
  output logic                 missed_ack_o
);

  logic       xfer_go;
  logic [6:0] xfer_addr;
  logic [7:0] xfer_data0;
  logic [7:0] xfer_data1;
  logic       busy;

  wb_i2c_cmd u_cmd (
    .clk          (clk),
    .rst          (rst),
    .wbs_adr_i    (wbs_adr_i),
    .wbs_dat_i    (wbs_dat_i),
    .wbs_we_i     (wbs_we_i),
    .wbs_stb_i    (wbs_stb_i),
    .wbs_cyc_i    (wbs_cyc_i),
    .wbs_ack_o    (wbs_ack_o),
    .busy_i       (busy),
    .xfer_go_o    (xfer_go),
    .xfer_addr_o  (xfer_addr),
    .xfer_data0_o (xfer_data0),
    .xfer_data1_o (xfer_data1)
  );

  i2c_master u_master (
    .clk          (clk),
    .rst          (rst),
    .xfer_go_i    (xfer_go),
    .xfer_addr_i  (xfer_addr),
    .xfer_data0_i (xfer_data0),
    .xfer_data1_i (xfer_data1),
    .scl_i        (scl_i),
    .sda_i        (sda_i),
    .busy_o       (busy),
    .missed_ack_o (missed_ack_o),
    .scl_t_o      (scl_t_o),
    .sda_t_o      (sda_t_o)
  );

endmodule

`default_nettype wire

// ==== verif/i2c_target_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_target_model #(
  parameter logic [6:0] own_addr = 7'h2a
) (
  input  wire  clk,
  input  wire  scl_i,
  input  wire  sda_i,
  input  wire  stretch_en_i,
  output logic scl_pull_o,
  output logic sda_pull_o
);

  // log codes above the byte range
  localparam int ev_start = 'h100;
  localparam int ev_stop  = 'h200;

  int         log_q[$];
  int         stop_cnt   = 0;
  int         hold       = 0;
  integer     seed       = 32'hc4f3;
  logic       scl_q      = 1'b1;
  logic       sda_q      = 1'b1;
  logic       in_frame   = 1'b0;
  logic       first_byte = 1'b0;
  logic       addressed  = 1'b0;
  logic       scl_low    = 1'b0;
  logic       sda_low    = 1'b0;
  logic [3:0] bit_cnt    = 4'd0;
  logic [7:0] shreg      = 8'd0;

  assign scl_pull_o = scl_low;
  assign sda_pull_o = sda_low;

  // lines sampled on the clock edge, pulls change 1 ns later
  always @(posedge clk) begin
    logic scl_s;
    logic sda_s;
    int   r;
    scl_s = scl_i;
    sda_s = sda_i;
    #1;
    if (hold > 0) begin
      hold = hold - 1;
      if (hold == 0) begin
        scl_low = 1'b0;
      end
    end
    if (scl_s && scl_q && sda_q && !sda_s) begin
      log_q.push_back(ev_start);
      in_frame   = 1'b1;
      first_byte = 1'b1;
      addressed  = 1'b0;
      bit_cnt    = 4'd0;
      sda_low    = 1'b0;
    end else if (scl_s && scl_q && !sda_q && sda_s) begin
      log_q.push_back(ev_stop);
      stop_cnt = stop_cnt + 1;
      in_frame = 1'b0;
      sda_low  = 1'b0;
    end else if (in_frame && !scl_q && scl_s) begin
      if (bit_cnt < 4'd8) begin
        shreg = {shreg[6:0], sda_s};
      end
      bit_cnt = bit_cnt + 4'd1;
      if (bit_cnt == 4'd8) begin
        log_q.push_back({24'd0, shreg});
        // address byte decides the acks of the whole frame
        if (first_byte) begin
          addressed = (shreg[7:1] == own_addr) && !shreg[0];
        end
        first_byte = 1'b0;
      end
    end else if (in_frame && scl_q && !scl_s) begin
      if (bit_cnt == 4'd8) begin
        sda_low = addressed;
      end else if (bit_cnt == 4'd9) begin
        sda_low = 1'b0;
        bit_cnt = 4'd0;
      end
      // holds longer than two quarters stall the master
      if (stretch_en_i) begin
        r       = $random(seed);
        hold    = r & 31;
        scl_low = (hold > 0);
      end
    end
    scl_q = scl_s;
    sda_q = sda_s;
  end

endmodule

`default_nettype wire

// ==== verif/tb_i2c_bus_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_i2c_bus_bridge import i2c_bridge_pkg::*; ();

  localparam int clk_period  = 100;
  localparam int drive_dly   = 1;
  localparam int n_cases     = 40;
  localparam int ack_wait    = 6;
  localparam int idle_cycles = 50;
  localparam int case_cycles = 4 * 9 * 4 * quarter_cycles + 1000;
  localparam int ev_start    = 'h100;
  localparam int ev_stop     = 'h200;
  localparam logic [6:0] own_addr = 7'h2a;

  logic                 clk = 1'b0;
  logic                 rst;
  logic [wb_addr_w-1:0] wbs_adr;
  logic [wb_data_w-1:0] wbs_dat;
  logic                 wbs_we;
  logic                 wbs_stb;
  logic                 wbs_cyc;
  logic                 wbs_ack;
  logic                 scl_t;
  logic                 sda_t;
  logic                 missed_ack;
  logic                 scl_pull;
  logic                 sda_pull;
  logic                 stretch_en;
  wire                  scl_line;
  wire                  sda_line;

  int     errors   = 0;
  int     checks   = 0;
  int     ack_cnt  = 0;
  int     miss_cnt = 0;
  integer seed;
  int     exp_q[$];

  // open-drain resolution
  assign scl_line = scl_t && !scl_pull;
  assign sda_line = sda_t && !sda_pull;

  always #(clk_period / 2) clk = ~clk;

  i2c_bus_bridge dut0 (
    .clk          (clk),
    .rst          (rst),
    .wbs_adr_i    (wbs_adr),
    .wbs_dat_i    (wbs_dat),
    .wbs_we_i     (wbs_we),
    .wbs_stb_i    (wbs_stb),
    .wbs_cyc_i    (wbs_cyc),
    .wbs_ack_o    (wbs_ack),
    .scl_i        (scl_line),
    .sda_i        (sda_line),
    .scl_t_o      (scl_t),
    .sda_t_o      (sda_t),
    .missed_ack_o (missed_ack)
  );

  i2c_target_model #(.own_addr(own_addr)) target0 (
    .clk          (clk),
    .scl_i        (scl_line),
    .sda_i        (sda_line),
    .stretch_en_i (stretch_en),
    .scl_pull_o   (scl_pull),
    .sda_pull_o   (sda_pull)
  );

  // pulse counters, sampled mid-cycle
  always @(negedge clk) begin
    if (wbs_ack) begin
      ack_cnt++;
    end
    if (missed_ack) begin
      miss_cnt++;
    end
  end

  task automatic check_val(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      $display("ERROR: %s", what);
      errors++;
    end
  endtask

  // holds the request until ack or until the host gives up
  task automatic bus_write(input logic [wb_addr_w-1:0] adr, input logic [wb_data_w-1:0] dat,
                           output int ack_at);
    int k;
    ack_at = 0;
    k      = 0;
    @(posedge clk);
    #drive_dly;
    wbs_adr = adr;
    wbs_dat = dat;
    wbs_we  = 1'b1;
    wbs_stb = 1'b1;
    wbs_cyc = 1'b1;
    while (ack_at == 0 && k < ack_wait) begin
      @(negedge clk);
      k++;
      if (wbs_ack) begin
        ack_at = k;
      end
    end
    @(posedge clk);
    #drive_dly;
    wbs_we  = 1'b0;
    wbs_stb = 1'b0;
    wbs_cyc = 1'b0;
  endtask

  task automatic wait_stop(input int base);
    int k;
    k = 0;
    while (target0.stop_cnt == base && k < case_cycles) begin
      @(negedge clk);
      k++;
    end
    check_true(target0.stop_cnt != base, "no STOP seen on the bus before the case timed out");
  endtask

  task automatic compare_log(input int base);
    int got_len;
    int i;
    got_len = target0.log_q.size() - base;
    check_val("target0.log_q length", got_len, exp_q.size());
    if (got_len == exp_q.size()) begin
      for (i = 0; i < got_len; i++) begin
        check_val($sformatf("target0.log_q[%0d]", base + i), target0.log_q[base + i], exp_q[i]);
      end
    end
  endtask

  initial begin
    int                   c;
    int                   r;
    int                   r2;
    int                   ack_at;
    int                   log_base;
    int                   stop_base;
    int                   ack_base;
    int                   miss_base;
    bit                   own_tgt;
    bit                   intrude;
    bit                   accepted;
    logic [wb_addr_w-1:0] adr;
    logic [7:0]           op;
    logic [6:0]           tgt;
    seed       = 32'hc4f3;
    rst        = 1'b1;
    wbs_adr    = '0;
    wbs_dat    = '0;
    wbs_we     = 1'b0;
    wbs_stb    = 1'b0;
    wbs_cyc    = 1'b0;
    stretch_en = 1'b0;
    repeat (2) @(posedge clk);
    #drive_dly;
    rst = 1'b0;
    @(negedge clk);
    check_val("scl_t_o", {31'd0, scl_t}, 1);
    check_val("sda_t_o", {31'd0, sda_t}, 1);
    check_val("wbs_ack_o", {31'd0, wbs_ack}, 0);
    check_val("missed_ack_o", {31'd0, missed_ack}, 0);

    for (c = 0; c < n_cases; c++) begin
      r  = $random(seed);
      r2 = $random(seed);
      own_tgt    = r[4];
      intrude    = r[5];
      stretch_en = r[6];
      adr = cmd_reg_addr;
      if (r[1:0] == 2'd0) begin
        adr = r[13:8];
        if (adr == cmd_reg_addr) begin
          adr = adr ^ 6'h01;
        end
      end
      op = OP_WRITE2;
      if (r[3:2] == 2'd0) begin
        op = r[23:16];
        if (op == OP_WRITE2) begin
          op = OP_NOP;
        end
      end
      tgt = own_addr;
      if (!own_tgt) begin
        tgt = r2[22:16];
        if (tgt == own_addr) begin
          tgt = tgt ^ 7'h01;
        end
      end
      accepted = (adr == cmd_reg_addr) && (op == OP_WRITE2);

      // expected bus events
      exp_q.delete();
      if (accepted) begin
        exp_q.push_back(ev_start);
        exp_q.push_back({24'd0, tgt, 1'b0});
        if (own_tgt) begin
          exp_q.push_back({24'd0, r2[15:8]});
          exp_q.push_back({24'd0, r2[7:0]});
        end
        exp_q.push_back(ev_stop);
      end

      log_base  = target0.log_q.size();
      stop_base = target0.stop_cnt;
      ack_base  = ack_cnt;
      miss_base = miss_cnt;
      bus_write(adr, {op, r2[23], tgt, r2[15:0]}, ack_at);
      check_val("wbs_ack_o cycle", ack_at, accepted ? 2 : 0);

      if (accepted && intrude) begin
        repeat (3) @(negedge clk);
        r = $random(seed);
        bus_write(cmd_reg_addr, {OP_WRITE2, r[23:0]}, ack_at);
        check_val("wbs_ack_o while busy", ack_at, 0);
      end

      if (accepted) begin
        wait_stop(stop_base);
      end else begin
        repeat (idle_cycles) @(negedge clk);
      end
      repeat (4) @(negedge clk);

      check_val("wbs_ack_o pulses", ack_cnt - ack_base, accepted ? 1 : 0);
      check_val("missed_ack_o pulses", miss_cnt - miss_base, (accepted && !own_tgt) ? 1 : 0);
      compare_log(log_base);
      check_val("scl_t_o", {31'd0, scl_t}, 1);
      check_val("sda_t_o", {31'd0, sda_t}, 1);
    end

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // worst case per transaction plus margin
  initial begin
    #(n_cases * case_cycles * clk_period);
    $display("watchdog expired before all cases finished, checks: %0d  errors: %0d",
             checks, errors);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== i2c_bus_bridge.f ====
source/i2c_bridge_pkg.sv
source/wb_i2c_cmd.sv
source/i2c_bit_timer.sv
source/i2c_byte_shift.sv
source/i2c_master.sv
source/i2c_bus_bridge.sv
verif/i2c_target_model.sv
verif/tb_i2c_bus_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the i2c bus bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

top=tb_i2c_bus_bridge
log=sim.log

verilator --binary --timing --assert --top-module "$top" -f i2c_bus_bridge.f -o "$top"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$log"; then
  exit 0
fi
echo "pass line not found in $log"
exit 1
